// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and judges the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert -f uf_decoding_graph.f \
    --top-module tb_uf_decoding_graph -o tb_sim > "$LOG" 2>&1 &&
    ./obj_dir/tb_sim >> "$LOG" 2>&1 ||
    echo "Result: FAILED" >> "$LOG"
cat "$LOG"
grep -q "Result: FAILED" "$LOG" && exit 1 || exit 0

// File: sim/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int HALF_PERIOD  = 20, // 40 ns clock
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // reset lets go on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/golden_decode.txt
// row0 row1 row2 in load order (row0 ends in the top round), grow_steps
// expected roots (node 11 down to node 0, 4 bits each), expected grown-link mask (23 bits)
0 0 0 3 ba9876543210 000000 // no defects
0 0 0 0 ba9876543210 000000 // no defects, grow skipped
0 2 0 1 ba9876543210 000000 // lone defect on node 5, half grown
0 2 0 2 ba1871113210 1100c0 // lone defect on node 5, all four links grown
0 0 c 1 ba9876542210 000008 // pair on nodes 2 and 3
1 1 0 1 ba9476543210 080000 // vertical pair on nodes 4 and 8
0 0 1 2 ba9876503200 008003 // corner defect on node 0
a 0 0 2 555556543210 507800 // nodes 9 and 11 join through node 10
0 b 8 1 ba9836443210 040040 // pair 4-5 and vertical pair 3-7
f f f 1 000000000000 7fb9ce // every node a defect, inner links only
f f f 2 000000000000 7fffff // every node a defect, boundaries too
0 4 0 f b29822243210 220180 // node 6 with growth saturated

// File: sim/tb_uf_decoding_graph.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uf_decoding_graph;

    import decoder_pkg::*;

    localparam int GRID_WIDTH_X  = 4;
    localparam int GRID_WIDTH_U  = 3;
    localparam int MAX_WEIGHT    = 2;
    localparam int ADDRESS_WIDTH = $clog2(GRID_WIDTH_X) + $clog2(GRID_WIDTH_U);
    localparam int NODE_COUNT    = GRID_WIDTH_X * GRID_WIDTH_U;
    localparam int LINK_COUNT    = (GRID_WIDTH_X + 1) * GRID_WIDTH_U
                                   + GRID_WIDTH_X * (GRID_WIDTH_U - 1);
    localparam int WORDS_PER_VEC = GRID_WIDTH_U + 3; // rows, steps, roots, link mask
    localparam int MAX_VECTORS   = 32;
    localparam int GOLDEN_WORDS  = MAX_VECTORS * WORDS_PER_VEC;
    localparam int DONE_TIMEOUT  = 200; // cycles from start to done
    localparam int RESET_TIMEOUT = 50;
    localparam int SEED          = 20888;

    logic                                clk;
    logic                                rst_n;
    logic                                start;
    logic [STEP_WIDTH-1:0]               grow_steps;
    logic [GRID_WIDTH_X-1:0]             measurements;
    logic                                busy;
    logic                                done;
    logic [ADDRESS_WIDTH*NODE_COUNT-1:0] roots;
    logic [LINK_COUNT-1:0]               grown_links;

    logic [63:0] golden_mem [0:GOLDEN_WORDS-1]; // one field per word and spare words all ones
    int          vector_count;
    int          check_count;

    clock_gen u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    uf_decoding_graph #(
        .GRID_WIDTH_X (GRID_WIDTH_X),
        .GRID_WIDTH_U (GRID_WIDTH_U),
        .MAX_WEIGHT   (MAX_WEIGHT)
    ) u_uf_decoding_graph (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .start_i        (start),
        .grow_steps_i   (grow_steps),
        .measurements_i (measurements),
        .busy_o         (busy),
        .done_o         (done),
        .roots_o        (roots),
        .grown_links_o  (grown_links)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string what);
        abort_run($sformatf("CHECK FAILED at time %0t: %s", $time, what));
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        check_count++;
        if (actual !== expected) begin
            report_mismatch($sformatf("%s is %b, expected %b", name, actual, expected));
        end
    endtask

    task automatic check_root(input int node, input logic [ADDRESS_WIDTH-1:0] expected);
        logic [ADDRESS_WIDTH-1:0] actual;
        actual = roots[node*ADDRESS_WIDTH +: ADDRESS_WIDTH]; // node = round*X + column
        check_count++;
        if (actual !== expected) begin
            report_mismatch($sformatf("root of node %0d is %0d, expected %0d",
                                      node, actual, expected));
        end
    endtask

    task automatic check_grown(input logic [LINK_COUNT-1:0] expected);
        check_count++;
        if (grown_links !== expected) begin
            report_mismatch($sformatf("grown_links_o is %h, expected %h",
                                      grown_links, expected));
        end
    endtask

    task automatic load_golden();
        for (int i = 0; i < GOLDEN_WORDS; i++) begin
            golden_mem[i] = '1; // marks the end of the vectors
        end
        $readmemh("sim/golden_decode.txt", golden_mem);
        vector_count = 0;
        while (vector_count < MAX_VECTORS && golden_mem[vector_count * WORDS_PER_VEC] != '1) begin
            vector_count++;
        end
        if (vector_count == 0) begin
            abort_run("the golden file sim/golden_decode.txt could not be read or is empty");
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                abort_run("reset was never released");
            end
        end
        @(negedge clk);
    endtask

    task automatic idle_gap();
        int unsigned gap;
        gap = $urandom_range(4, 1);
        repeat (gap) begin
            @(negedge clk);
            check_flag("done_o while idle", done, 1'b0);
            check_flag("busy_o while idle", busy, 1'b0);
        end
    endtask

    // one decode from start to done
    task automatic run_vector(input int v, input bit stray);
        int                    base;
        int                    cycles;
        logic [LINK_COUNT-1:0] mask_exp;
        base       = v * WORDS_PER_VEC;
        mask_exp   = golden_mem[base + GRID_WIDTH_U + 2][LINK_COUNT-1:0];
        start      = 1'b1;
        grow_steps = golden_mem[base + GRID_WIDTH_U][STEP_WIDTH-1:0]; // taken with start
        for (int c = 0; c < GRID_WIDTH_U; c++) begin
            @(negedge clk);
            start        = 1'b0;
            measurements = golden_mem[base + c][GRID_WIDTH_X-1:0]; // first row ends on top
            check_flag("busy_o during load", busy, 1'b1);
        end
        @(negedge clk);
        measurements = '0;
        cycles       = 0;
        while (done !== 1'b1) begin
            check_flag("busy_o while decoding", busy, 1'b1);
            if (stray) begin
                // load is over so every cycle until done is grow or merge
                start      = 1'b1;
                grow_steps = STEP_WIDTH'($urandom_range(15, 0));
            end
            cycles++;
            if (cycles > DONE_TIMEOUT) begin
                abort_run($sformatf("timeout, no done_o pulse within %0d cycles on vector %0d",
                                    DONE_TIMEOUT, v));
            end
            @(negedge clk);
        end
        start = 1'b0; // a start in the done stage would be taken
        check_flag("busy_o with done_o", busy, 1'b0);
        for (int n = 0; n < NODE_COUNT; n++) begin
            check_root(n, golden_mem[base + GRID_WIDTH_U + 1][n*ADDRESS_WIDTH +: ADDRESS_WIDTH]);
        end
        check_grown(mask_exp);
        repeat (3) begin
            @(negedge clk);
            check_flag("done_o after its pulse", done, 1'b0); // exactly one pulse
            check_flag("busy_o after done_o", busy, 1'b0);
        end
        check_grown(mask_exp); // results hold until the next start
    endtask

    initial begin
        start        = 1'b0;
        grow_steps   = '0;
        measurements = '0;
        check_count  = 0;
        void'($urandom(SEED));
        load_golden();
        wait_reset_release();
        check_flag("busy_o after reset", busy, 1'b0);
        check_flag("done_o after reset", done, 1'b0);
        for (int v = 0; v < vector_count; v++) begin
            idle_gap();
            run_vector(v, v % 2 == 1); // odd vectors get stray starts
        end
        if (check_count > 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            abort_run("no checks were run");
        end
    end

endmodule

`default_nettype wire

// File: source/decoder_pkg.sv
`default_nettype none

package decoder_pkg;

    // decoding stage, driven by the controller to every node and link
    typedef enum logic [2:0] {
        STAGE_IDLE  = 3'd0, // waiting for start
        STAGE_LOAD  = 3'd1, // syndrome rows shift into the grid
        STAGE_GROW  = 3'd2, // links grow from defect nodes
        STAGE_MERGE = 3'd3, // roots converge across grown links
        STAGE_DONE  = 3'd4  // results held until the next start
    } stage_t;

    // link ports on each node
    localparam int NEIGHBOR_COUNT = 4;

    // neighbor index of each link port
    localparam int NEIGHBOR_WEST = 0; // lower column, same round
    localparam int NEIGHBOR_EAST = 1; // higher column, same round
    localparam int NEIGHBOR_DOWN = 2; // same column, round below
    localparam int NEIGHBOR_UP   = 3; // same column, round above

    // width of the load and grow step count
    localparam int STEP_WIDTH = 4;

endpackage

`default_nettype wire

// File: source/link_unit.sv
`timescale 1ns/1ps
`default_nettype none

module link_unit #(
    parameter int MAX_WEIGHT = 2 // growth at which the link counts as grown
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  decoder_pkg::stage_t stage_i,
    input  logic                a_defect_i,
    input  logic                b_defect_i, // zero on boundary links
    output logic                fully_grown_o
);

    import decoder_pkg::*;

    localparam int LINK_BIT_WIDTH = $clog2(MAX_WEIGHT + 1);

    logic [LINK_BIT_WIDTH-1:0] growth_q;
    logic [1:0]                increase;   // defect endpoints, 0 to 2
    logic [LINK_BIT_WIDTH:0]   growth_sum; // one spare bit before saturation

    assign increase   = {1'b0, a_defect_i} + {1'b0, b_defect_i};
    assign growth_sum = (LINK_BIT_WIDTH + 1)'(growth_q) + (LINK_BIT_WIDTH + 1)'(increase);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            growth_q <= '0;
        end else if (stage_i == STAGE_LOAD) begin
            growth_q <= '0; // cleared for the new decode
        end else if (stage_i == STAGE_GROW) begin
            // saturate at the link weight
            if (growth_sum >= (LINK_BIT_WIDTH + 1)'(MAX_WEIGHT)) begin
                growth_q <= LINK_BIT_WIDTH'(MAX_WEIGHT);
            end else begin
                growth_q <= growth_sum[LINK_BIT_WIDTH-1:0];
            end
        end
    end

    assign fully_grown_o = (growth_q == LINK_BIT_WIDTH'(MAX_WEIGHT));

    // saturation holds across every grow step
    growth_in_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        growth_q <= LINK_BIT_WIDTH'(MAX_WEIGHT))
        else $error("link growth beyond weight");

endmodule

`default_nettype wire

// File: source/node_unit.sv
`timescale 1ns/1ps
`default_nettype none

module node_unit #(
    parameter int                       ADDRESS_WIDTH = 4,
    parameter logic [ADDRESS_WIDTH-1:0] NODE_ADDRESS  = '0 // round in high bits, column low
) (
    input  logic                                                  clk,
    input  logic                                                  rst_n_i,
    input  decoder_pkg::stage_t                                   stage_i,
    input  logic                                                  measurement_i,
    output logic                                                  measurement_o,
    input  logic [decoder_pkg::NEIGHBOR_COUNT-1:0]                neighbor_fully_grown_i,
    input  logic [decoder_pkg::NEIGHBOR_COUNT-1:0][ADDRESS_WIDTH-1:0] neighbor_root_i,
    output logic                                                  defect_o,
    output logic [ADDRESS_WIDTH-1:0]                              root_o,
    output logic                                                  changed_o
);

    import decoder_pkg::*;

    logic                     measurement_q; // syndrome bit for this node
    logic [ADDRESS_WIDTH-1:0] root_q;
    logic [ADDRESS_WIDTH-1:0] root_min;      // smallest root seen over grown links

    // shift chain, one round per load cycle
    always_ff @(posedge clk) begin
        if (stage_i == STAGE_LOAD) measurement_q <= measurement_i;
    end

    always_comb begin
        root_min = root_q;
        for (int n = 0; n < NEIGHBOR_COUNT; n++) begin
            // only fully grown links join clusters
            if (neighbor_fully_grown_i[n] && (neighbor_root_i[n] < root_min)) begin
                root_min = neighbor_root_i[n];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            root_q <= NODE_ADDRESS;
        end else if (stage_i == STAGE_LOAD) begin
            root_q <= NODE_ADDRESS; // new decode, every node its own cluster
        end else if (stage_i == STAGE_MERGE) begin
            root_q <= root_min;
        end
    end

    assign measurement_o = measurement_q; // passed to the next round
    assign defect_o      = measurement_q;
    assign root_o        = root_q;
    assign changed_o     = (stage_i == STAGE_MERGE) && (root_min != root_q);

    // roots only ever move to smaller addresses
    root_not_above_self: assert property (@(posedge clk) disable iff (!rst_n_i)
        root_q <= NODE_ADDRESS)
        else $error("node root above own address");

endmodule

`default_nettype wire

// File: source/stage_controller.sv
`timescale 1ns/1ps
`default_nettype none

module stage_controller #(
    parameter int GRID_WIDTH_U = 3 // rounds, sets the length of load
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                start_i,
    input  logic [decoder_pkg::STEP_WIDTH-1:0]  grow_steps_i,
    input  logic                                zero_i,        // step counter expired
    input  logic                                any_changed_i, // some root moved this cycle
    output decoder_pkg::stage_t                 stage_o,
    output logic                                load_o,
    output logic [decoder_pkg::STEP_WIDTH-1:0]  load_value_o,
    output logic                                busy_o,
    output logic                                done_o
);

    import decoder_pkg::*;

    stage_t                stage_q;
    stage_t                stage_d;
    logic [STEP_WIDTH-1:0] grow_steps_q; // grow count taken at start
    logic                  busy_q;
    logic                  done_q;
    logic                  start_ok;     // start accepted this cycle
    logic                  merge_end;    // merge settled this cycle

    // start only counts when nothing is running
    assign start_ok  = start_i && (stage_q == STAGE_IDLE || stage_q == STAGE_DONE);
    assign merge_end = (stage_q == STAGE_MERGE) && !any_changed_i;

    always_comb begin
        stage_d      = stage_q;
        load_o       = 1'b0;
        load_value_o = '0;
        case (stage_q)
            STAGE_IDLE, STAGE_DONE: begin
                if (start_ok) begin
                    stage_d      = STAGE_LOAD;
                    load_o       = 1'b1;
                    load_value_o = STEP_WIDTH'(GRID_WIDTH_U - 1); // one cycle per round
                end
            end
            STAGE_LOAD: begin
                if (zero_i) begin
                    if (grow_steps_q == '0) begin
                        stage_d = STAGE_MERGE; // nothing to grow
                    end else begin
                        stage_d      = STAGE_GROW;
                        load_o       = 1'b1;
                        load_value_o = grow_steps_q - 1'b1;
                    end
                end
            end
            STAGE_GROW:  if (zero_i) stage_d = STAGE_MERGE;
            STAGE_MERGE: if (merge_end) stage_d = STAGE_DONE;
            default:     stage_d = STAGE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            stage_q <= STAGE_IDLE;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            stage_q <= stage_d;
            done_q  <= merge_end; // single pulse, stage leaves merge at once
            if (start_ok) begin
                busy_q <= 1'b1;
            end else if (merge_end) begin
                busy_q <= 1'b0; // falls together with done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) grow_steps_q <= grow_steps_i;
    end

    assign stage_o = stage_q;
    assign busy_o  = busy_q;
    assign done_o  = done_q;

    // state register only ever holds one of the five stages
    stage_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
        stage_q inside {STAGE_IDLE, STAGE_LOAD, STAGE_GROW, STAGE_MERGE, STAGE_DONE})
        else $error("stage register holds an illegal value");

endmodule

`default_nettype wire

// File: source/step_counter.sv
`timescale 1ns/1ps
`default_nettype none

module step_counter (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               load_i,
    input  logic [decoder_pkg::STEP_WIDTH-1:0] load_value_i,
    output logic                               zero_o
);

    import decoder_pkg::*;

    logic [STEP_WIDTH-1:0] count_q;

    // down-counter, sits at zero once expired
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= load_value_i;
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign zero_o = (count_q == '0); // last cycle of the timed stage

    // controller only reloads after the previous stage ran out
    no_load_mid_count: assert property (@(posedge clk) disable iff (!rst_n_i)
        load_i |-> zero_o)
        else $error("step counter reloaded while still counting");

endmodule

`default_nettype wire

// File: source/uf_decoding_graph.sv
`timescale 1ns/1ps
`default_nettype none

module uf_decoding_graph #(
    parameter int GRID_WIDTH_X = 4, // nodes per round
    parameter int GRID_WIDTH_U = 3, // rounds
    parameter int MAX_WEIGHT   = 2,
    localparam int X_BIT_WIDTH   = $clog2(GRID_WIDTH_X),
    localparam int U_BIT_WIDTH   = $clog2(GRID_WIDTH_U),
    localparam int ADDRESS_WIDTH = X_BIT_WIDTH + U_BIT_WIDTH,
    localparam int NODE_COUNT    = GRID_WIDTH_X * GRID_WIDTH_U,
    localparam int H_LINK_COUNT  = (GRID_WIDTH_X + 1) * GRID_WIDTH_U,     // boundaries included
    localparam int LINK_COUNT    = H_LINK_COUNT + GRID_WIDTH_X * (GRID_WIDTH_U - 1)
) (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic                                 start_i,
    input  logic [decoder_pkg::STEP_WIDTH-1:0]   grow_steps_i,
    input  logic [GRID_WIDTH_X-1:0]              measurements_i, // one round per load cycle
    output logic                                 busy_o,
    output logic                                 done_o,
    output logic [ADDRESS_WIDTH*NODE_COUNT-1:0]  roots_o,        // node index is round*X + column
    output logic [LINK_COUNT-1:0]                grown_links_o
);

    import decoder_pkg::*;

    stage_t                stage;
    logic                  cnt_load;
    logic [STEP_WIDTH-1:0] cnt_load_value;
    logic                  cnt_zero;
    logic                  any_changed;
    wire                   tie_zero; // far end of boundary links, missing time links

    wire [NODE_COUNT-1:0]                                node_meas_in;
    wire [NODE_COUNT-1:0]                                node_meas;
    wire [NODE_COUNT-1:0]                                node_defect;
    wire [NODE_COUNT-1:0]                                node_changed;
    wire [NODE_COUNT-1:0][ADDRESS_WIDTH-1:0]             node_root;
    wire [NODE_COUNT-1:0][NEIGHBOR_COUNT-1:0]            node_fg;
    wire [NODE_COUNT-1:0][NEIGHBOR_COUNT-1:0][ADDRESS_WIDTH-1:0] node_nbr_root;
    wire [LINK_COUNT-1:0]                                link_grown;

    assign tie_zero    = 1'b0;
    assign any_changed = |node_changed;
    assign roots_o     = node_root;
    assign grown_links_o = link_grown;

    stage_controller #(
        .GRID_WIDTH_U (GRID_WIDTH_U)
    ) u_stage_controller (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .start_i       (start_i),
        .grow_steps_i  (grow_steps_i),
        .zero_i        (cnt_zero),
        .any_changed_i (any_changed),
        .stage_o       (stage),
        .load_o        (cnt_load),
        .load_value_o  (cnt_load_value),
        .busy_o        (busy_o),
        .done_o        (done_o)
    );

    step_counter u_step_counter (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .load_i       (cnt_load),
        .load_value_i (cnt_load_value),
        .zero_o       (cnt_zero)
    );

    genvar r, c, l;
    generate
        for (r = 0; r < GRID_WIDTH_U; r++) begin : node_r
            for (c = 0; c < GRID_WIDTH_X; c++) begin : node_c
                localparam int N = r * GRID_WIDTH_X + c;
                localparam logic [ADDRESS_WIDTH-1:0] ADDR =
                    ADDRESS_WIDTH'((r << X_BIT_WIDTH) + c);

                // rows enter at round 0 and move up, first row ends on top
                if (r == 0) begin : chain_head
                    assign node_meas_in[N] = measurements_i[c];
                end else begin : chain_body
                    assign node_meas_in[N] = node_meas[N - GRID_WIDTH_X];
                end

                // no time boundary below round 0 or above the top round
                if (r == 0) begin : no_down
                    assign node_fg[N][NEIGHBOR_DOWN]       = tie_zero;
                    assign node_nbr_root[N][NEIGHBOR_DOWN] = node_root[N];
                end
                if (r == GRID_WIDTH_U - 1) begin : no_up
                    assign node_fg[N][NEIGHBOR_UP]       = tie_zero;
                    assign node_nbr_root[N][NEIGHBOR_UP] = node_root[N];
                end

                node_unit #(
                    .ADDRESS_WIDTH (ADDRESS_WIDTH),
                    .NODE_ADDRESS  (ADDR)
                ) u_node (
                    .clk                    (clk),
                    .rst_n_i                (rst_n_i),
                    .stage_i                (stage),
                    .measurement_i          (node_meas_in[N]),
                    .measurement_o          (node_meas[N]),
                    .neighbor_fully_grown_i (node_fg[N]),
                    .neighbor_root_i        (node_nbr_root[N]),
                    .defect_o               (node_defect[N]),
                    .root_o                 (node_root[N]),
                    .changed_o              (node_changed[N])
                );
            end
        end

        // horizontal links, X+1 per round from west boundary to east boundary
        for (r = 0; r < GRID_WIDTH_U; r++) begin : hlink_r
            for (l = 0; l <= GRID_WIDTH_X; l++) begin : hlink_l
                localparam int H = r * (GRID_WIDTH_X + 1) + l;
                localparam int W = r * GRID_WIDTH_X + l - 1; // node west of the link
                localparam int E = r * GRID_WIDTH_X + l;     // node east of the link

                if (l == 0) begin : west_edge
                    link_unit #(.MAX_WEIGHT(MAX_WEIGHT)) u_link (
                        .clk (clk), .rst_n_i (rst_n_i), .stage_i (stage),
                        .a_defect_i (node_defect[E]), .b_defect_i (tie_zero),
                        .fully_grown_o (link_grown[H])
                    );
                    assign node_fg[E][NEIGHBOR_WEST]       = link_grown[H];
                    assign node_nbr_root[E][NEIGHBOR_WEST] = node_root[E]; // merges nothing
                end else if (l == GRID_WIDTH_X) begin : east_edge
                    link_unit #(.MAX_WEIGHT(MAX_WEIGHT)) u_link (
                        .clk (clk), .rst_n_i (rst_n_i), .stage_i (stage),
                        .a_defect_i (node_defect[W]), .b_defect_i (tie_zero),
                        .fully_grown_o (link_grown[H])
                    );
                    assign node_fg[W][NEIGHBOR_EAST]       = link_grown[H];
                    assign node_nbr_root[W][NEIGHBOR_EAST] = node_root[W];
                end else begin : inner
                    link_unit #(.MAX_WEIGHT(MAX_WEIGHT)) u_link (
                        .clk (clk), .rst_n_i (rst_n_i), .stage_i (stage),
                        .a_defect_i (node_defect[W]), .b_defect_i (node_defect[E]),
                        .fully_grown_o (link_grown[H])
                    );
                    assign node_fg[W][NEIGHBOR_EAST]       = link_grown[H];
                    assign node_fg[E][NEIGHBOR_WEST]       = link_grown[H];
                    assign node_nbr_root[W][NEIGHBOR_EAST] = node_root[E]; // each end sees the other
                    assign node_nbr_root[E][NEIGHBOR_WEST] = node_root[W];
                end
            end
        end

        // vertical links between round r and r+1, after all horizontal ones
        for (r = 0; r < GRID_WIDTH_U - 1; r++) begin : vlink_r
            for (c = 0; c < GRID_WIDTH_X; c++) begin : vlink_c
                localparam int V  = H_LINK_COUNT + r * GRID_WIDTH_X + c;
                localparam int LO = r * GRID_WIDTH_X + c;
                localparam int HI = LO + GRID_WIDTH_X;

                link_unit #(.MAX_WEIGHT(MAX_WEIGHT)) u_link (
                    .clk (clk), .rst_n_i (rst_n_i), .stage_i (stage),
                    .a_defect_i (node_defect[LO]), .b_defect_i (node_defect[HI]),
                    .fully_grown_o (link_grown[V])
                );
                assign node_fg[LO][NEIGHBOR_UP]         = link_grown[V];
                assign node_fg[HI][NEIGHBOR_DOWN]       = link_grown[V];
                assign node_nbr_root[LO][NEIGHBOR_UP]   = node_root[HI];
                assign node_nbr_root[HI][NEIGHBOR_DOWN] = node_root[LO];
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: uf_decoding_graph.f
source/decoder_pkg.sv
source/stage_controller.sv
source/step_counter.sv
source/node_unit.sv
source/link_unit.sv
source/uf_decoding_graph.sv
sim/clock_gen.sv
sim/tb_uf_decoding_graph.sv
